// File: design/rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           run,
  input  logic                           prog_we,
  input  logic [rv_pkg::IMEM_AWIDTH-1:0] prog_addr,
  input  rv_pkg::inst_t                  prog_data,
  output logic [rv_pkg::XLEN-1:0]        csr,
  output logic                           csr_we
);

  rv_pkg::inst_t                  inst;
  logic                           inst_valid;
  rv_pkg::id_ex_t                 id_ex;
  rv_pkg::wb_t                    wb;
  logic [rv_pkg::DMEM_AWIDTH-1:0] dmem_addr;
  logic [rv_pkg::XLEN-1:0]        dmem_wdata;
  logic [3:0]                     dmem_be;
  logic                           dmem_rd;
  logic [4:0]                     ex_rd;
  logic                           ex_reg_we;
  logic [rv_pkg::XLEN-1:0]        ex_result;
  rv_pkg::wb_sel_e                ex_wb_sel;
  logic [2:0]                     ex_funct3;
  logic [1:0]                     ex_byte_off;

  rv_fetch i_fetch (
    .clk(clk), .rst_n(rst_n), .run(run), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .inst(inst), .inst_valid(inst_valid)
  );

  // Write-back feeds decode and execute for forwarding
  rv_decode i_decode (
    .clk(clk), .rst_n(rst_n), .inst(inst), .inst_valid(inst_valid), .wb(wb), .id_ex(id_ex)
  );

  rv_execute i_execute (
    .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .wb(wb),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_be(dmem_be), .dmem_rd(dmem_rd),
    .ex_rd(ex_rd), .ex_reg_we(ex_reg_we), .ex_result(ex_result), .ex_wb_sel(ex_wb_sel),
    .ex_funct3(ex_funct3), .ex_byte_off(ex_byte_off), .csr(csr), .csr_we(csr_we)
  );

  rv_mem_stage i_mem_stage (
    .clk(clk), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_be(dmem_be),
    .dmem_rd(dmem_rd), .ex_rd(ex_rd), .ex_reg_we(ex_reg_we), .ex_result(ex_result),
    .ex_wb_sel(ex_wb_sel), .ex_funct3(ex_funct3), .ex_byte_off(ex_byte_off), .wb(wb)
  );

endmodule

// File: design/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
  input  logic           clk,
  input  logic           rst_n,
  input  rv_pkg::inst_t  inst,
  input  logic           inst_valid,
  input  rv_pkg::wb_t    wb,
  output rv_pkg::id_ex_t id_ex
);

  logic [rv_pkg::XLEN-1:0] rs1_data;
  logic [rv_pkg::XLEN-1:0] rs2_data;
  rv_pkg::id_ex_t          dec;
  logic                    known;
  logic                    imm_alt;

  // funct3 to ALU op, alt picks SUB and SRA
  function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  rv_regfile i_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (inst.r_fmt.rs1),
    .rs2_addr (inst.r_fmt.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  // ADDI with a negative immediate must not turn into SUB
  assign imm_alt = (inst.i_fmt.funct3 == 3'b101) & inst.i_fmt.imm[10];

  always_comb begin
    dec          = '0;
    known        = 1'b1;
    dec.rs1_data = rs1_data;
    dec.rs2_data = rs2_data;
    dec.rs1      = inst.r_fmt.rs1;
    dec.rs2      = inst.r_fmt.rs2;
    dec.rd       = inst.r_fmt.rd;
    dec.funct3   = inst.r_fmt.funct3;
    dec.imm      = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    dec.alu_op   = rv_pkg::ALU_ADD;
    case (inst.r_fmt.opcode)
      rv_pkg::OPC_OP: begin
        dec.alu_op = alu_decode(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
        dec.reg_we = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        dec.alu_op  = alu_decode(inst.i_fmt.funct3, imm_alt);
        dec.use_imm = 1'b1;
        dec.reg_we  = 1'b1;
      end
      rv_pkg::OPC_LUI: begin
        dec.imm     = {inst.u_fmt.imm, 12'b0};
        dec.alu_op  = rv_pkg::ALU_PASS_B;
        dec.use_imm = 1'b1;
        dec.reg_we  = 1'b1;
      end
      rv_pkg::OPC_LOAD: begin
        dec.use_imm = 1'b1;  // Address is rs1 + imm
        dec.reg_we  = 1'b1;
        dec.mem_rd  = 1'b1;
      end
      rv_pkg::OPC_STORE: begin
        dec.imm     = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
        dec.use_imm = 1'b1;
        dec.mem_we  = 1'b1;
      end
      rv_pkg::OPC_SYSTEM: begin
        // Only CSRRW, imm carries the CSR address
        dec.csr_we = (inst.i_fmt.funct3 == 3'b001);
        known      = dec.csr_we;
      end
      default: known = 1'b0;
    endcase
    dec.valid  = inst_valid & known;
    dec.reg_we = dec.reg_we & (dec.rd != 5'd0);  // x0 never forwards
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else begin
      id_ex <= dec;
    end
  end

endmodule

// File: design/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
  input  logic                           clk,
  input  logic                           rst_n,
  input  rv_pkg::id_ex_t                 id_ex,
  input  rv_pkg::wb_t                    wb,
  output logic [rv_pkg::DMEM_AWIDTH-1:0] dmem_addr,
  output logic [rv_pkg::XLEN-1:0]        dmem_wdata,
  output logic [3:0]                     dmem_be,
  output logic                           dmem_rd,
  output logic [4:0]                     ex_rd,
  output logic                           ex_reg_we,
  output logic [rv_pkg::XLEN-1:0]        ex_result,
  output rv_pkg::wb_sel_e                ex_wb_sel,
  output logic [2:0]                     ex_funct3,
  output logic [1:0]                     ex_byte_off,
  output logic [rv_pkg::XLEN-1:0]        csr,
  output logic                           csr_we
);

  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] rs2_val;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] alu_res;
  logic                    csr_hit;

  // Result of the instruction one ahead, now in write-back
  function automatic logic [rv_pkg::XLEN-1:0] fwd(input rv_pkg::wb_t w, input logic [4:0] idx,
                                                   input logic [rv_pkg::XLEN-1:0] rf_val);
    return (w.reg_we && w.rd == idx) ? w.data : rf_val;
  endfunction

  assign op_a    = fwd(wb, id_ex.rs1, id_ex.rs1_data);
  assign rs2_val = fwd(wb, id_ex.rs2, id_ex.rs2_data);
  assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_val;

  always_comb begin
    case (id_ex.alu_op)
      rv_pkg::ALU_ADD:  alu_res = op_a + op_b;
      rv_pkg::ALU_SUB:  alu_res = op_a - op_b;
      rv_pkg::ALU_AND:  alu_res = op_a & op_b;
      rv_pkg::ALU_OR:   alu_res = op_a | op_b;
      rv_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      rv_pkg::ALU_SLL:  alu_res = op_a << op_b[4:0];
      rv_pkg::ALU_SRL:  alu_res = op_a >> op_b[4:0];
      rv_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      rv_pkg::ALU_SLT:  alu_res = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU: alu_res = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
      default:          alu_res = op_b;  // LUI
    endcase
  end

  // Word address to the RAM, byte lanes from the low bits
  assign dmem_addr = alu_res[rv_pkg::DMEM_AWIDTH+1:2];
  assign dmem_rd   = id_ex.valid & id_ex.mem_rd;

  always_comb begin
    if (id_ex.funct3[1]) begin  // SW
      dmem_wdata = rs2_val;
      dmem_be    = 4'b1111;
    end else begin  // SB, byte replicated on every lane
      dmem_wdata = {4{rs2_val[7:0]}};
      dmem_be    = 4'b0001 << alu_res[1:0];
    end
    if (!(id_ex.valid && id_ex.mem_we)) begin
      dmem_be = 4'b0000;
    end
  end

  assign csr_hit = id_ex.valid & id_ex.csr_we & (id_ex.imm[11:0] == rv_pkg::CSR_TOHOST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_reg_we <= 1'b0;
      csr_we    <= 1'b0;
      csr       <= '0;
    end else begin
      ex_reg_we <= id_ex.valid & id_ex.reg_we;
      csr_we    <= csr_hit;  // One-cycle strobe
      if (csr_hit) begin
        csr <= op_a;
      end
    end
  end

  always_ff @(posedge clk) begin
    ex_rd       <= id_ex.rd;
    ex_result   <= alu_res;
    ex_wb_sel   <= id_ex.mem_rd ? rv_pkg::WB_LOAD : rv_pkg::WB_ALU;
    ex_funct3   <= id_ex.funct3;
    ex_byte_off <= alu_res[1:0];
  end

endmodule

// File: design/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         run,
  input  logic                         prog_we,
  input  logic [rv_pkg::IMEM_AWIDTH-1:0] prog_addr,
  input  rv_pkg::inst_t                prog_data,
  output rv_pkg::inst_t                inst,
  output logic                         inst_valid
);

  logic [rv_pkg::XLEN-1:0] pc;
  rv_pkg::inst_t           imem [2**rv_pkg::IMEM_AWIDTH];

  // Program port writes, PC port reads one cycle late
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
    if (run) begin
      inst <= imem[pc[rv_pkg::IMEM_AWIDTH+1:2]];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= '0;
      inst_valid <= 1'b0;
    end else begin
      inst_valid <= run;  // Tracks the read above
      if (run) begin
        pc <= pc + rv_pkg::XLEN'(4);
      end
    end
  end

endmodule

// File: design/rv_mem_stage.sv
`timescale 1ns/10ps

module rv_mem_stage (
  input  logic                           clk,
  input  logic [rv_pkg::DMEM_AWIDTH-1:0] dmem_addr,
  input  logic [rv_pkg::XLEN-1:0]        dmem_wdata,
  input  logic [3:0]                     dmem_be,
  input  logic                           dmem_rd,
  input  logic [4:0]                     ex_rd,
  input  logic                           ex_reg_we,
  input  logic [rv_pkg::XLEN-1:0]        ex_result,
  input  rv_pkg::wb_sel_e                ex_wb_sel,
  input  logic [2:0]                     ex_funct3,
  input  logic [1:0]                     ex_byte_off,
  output rv_pkg::wb_t                    wb
);

  logic [rv_pkg::XLEN-1:0] dmem [2**rv_pkg::DMEM_AWIDTH];
  logic [rv_pkg::XLEN-1:0] dmem_q;
  logic [rv_pkg::XLEN-1:0] lane;
  logic [rv_pkg::XLEN-1:0] load_data;

  // Byte-enable write, registered read
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (dmem_be[i]) begin
        dmem[dmem_addr][i*8 +: 8] <= dmem_wdata[i*8 +: 8];
      end
    end
    if (dmem_rd) begin
      dmem_q <= dmem[dmem_addr];
    end
  end

  assign lane = dmem_q >> {ex_byte_off, 3'b000};

  always_comb begin
    if (ex_funct3[1]) begin
      load_data = dmem_q;                      // LW
    end else if (ex_funct3[2]) begin
      load_data = {24'b0, lane[7:0]};          // LBU
    end else begin
      load_data = {{24{lane[7]}}, lane[7:0]};  // LB
    end
  end

  assign wb.reg_we = ex_reg_we;
  assign wb.rd     = ex_rd;
  assign wb.data   = (ex_wb_sel == rv_pkg::WB_LOAD) ? load_data : ex_result;

endmodule

// File: design/rv_pkg.sv
package rv_pkg;

  localparam int XLEN        = 32;
  localparam int IMEM_AWIDTH = 8;   // 256 instruction words
  localparam int DMEM_AWIDTH = 8;

  localparam logic [11:0] CSR_TOHOST = 12'h51E;

  // Base opcodes kept by the core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // One instruction word, four encodings
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } inst_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
  } alu_op_e;

  typedef enum logic {
    WB_ALU,
    WB_LOAD
  } wb_sel_e;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    alu_op_e         alu_op;
    logic            use_imm;
    logic            reg_we;
    logic            mem_we;
    logic            mem_rd;
    logic [2:0]      funct3;
    logic            csr_we;
  } id_ex_t;

  typedef struct packed {
    logic            reg_we;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } wb_t;

endpackage

// File: design/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [4:0]              rs1_addr,
  input  logic [4:0]              rs2_addr,
  output logic [rv_pkg::XLEN-1:0] rs1_data,
  output logic [rv_pkg::XLEN-1:0] rs2_data,
  input  rv_pkg::wb_t             wb
);

  logic [rv_pkg::XLEN-1:0] regs [1:31];  // x0 has no storage

  // Write-through so an instruction two behind sees the new value
  function automatic logic [rv_pkg::XLEN-1:0] rd_port(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return '0;
    end
    return (wb.reg_we && wb.rd == addr) ? wb.data : regs[addr];
  endfunction

  always_comb begin
    rs1_data = rd_port(rs1_addr);
    rs2_data = rd_port(rs2_addr);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.reg_we && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule

// File: flist.f
+incdir+testbench
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_mem_stage.sv
design/rv_core.sv
testbench/rv_core_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --timescale 1ns/10ps --top-module rv_core_tb \
  -f flist.f -o rv_core_sim &&
  ./obj_dir/rv_core_sim || exit 1

// File: testbench/rv_ref_model.svh
typedef logic [31:0] word_q_t [$];

// Encoders fill the instruction union through its format views
function automatic rv_pkg::inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
  rv_pkg::inst_t w;
  w.r_fmt = '{f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  return w;
endfunction

function automatic rv_pkg::inst_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
  rv_pkg::inst_t w;
  w.i_fmt = '{imm, rs1, f3, rd, opc};
  return w;
endfunction

function automatic rv_pkg::inst_t enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [11:0] imm);
  rv_pkg::inst_t w;
  w.s_fmt = '{imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_STORE};
  return w;
endfunction

function automatic rv_pkg::inst_t enc_u(input logic [4:0] rd, input logic [19:0] imm);
  rv_pkg::inst_t w;
  w.u_fmt = '{imm, rd, rv_pkg::OPC_LUI};
  return w;
endfunction

// Runs the program in order, returns every value written to CSR 0x51E
function automatic word_q_t ref_csr_writes(input rv_pkg::inst_t code [$]);
  logic [31:0]   x [32];
  logic [7:0]    mem [1024];  // Byte addressed
  word_q_t       out;
  rv_pkg::inst_t w;
  logic [31:0]   a, b, imm, res;
  logic [9:0]    ba;
  logic          alt;
  logic          wr;
  foreach (x[r]) x[r] = '0;
  foreach (code[n]) begin
    w   = code[n];
    a   = x[w.r_fmt.rs1];
    b   = x[w.r_fmt.rs2];
    imm = {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
    res = '0;
    wr  = 1'b1;
    case (w.r_fmt.opcode)
      rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
        // Bit 30 selects SUB and SRA, for immediates only on the shift
        alt = w.r_fmt.funct7[5] &
              (w.r_fmt.opcode == rv_pkg::OPC_OP || w.r_fmt.funct3 == 3'b101);
        if (w.r_fmt.opcode == rv_pkg::OPC_OP_IMM) begin
          b = imm;
        end
        case (w.r_fmt.funct3)
          3'b000: res = alt ? a - b : a + b;
          3'b001: res = a << b[4:0];
          3'b010: res = {31'b0, $signed(a) < $signed(b)};
          3'b011: res = {31'b0, a < b};
          3'b100: res = a ^ b;
          3'b101: begin
            if (alt) begin
              res = $signed(a) >>> b[4:0];
            end else begin
              res = a >> b[4:0];
            end
          end
          3'b110:  res = a | b;
          default: res = a & b;
        endcase
      end
      rv_pkg::OPC_LUI: res = {w.u_fmt.imm, 12'b0};
      rv_pkg::OPC_LOAD: begin
        ba = 10'(a + imm);
        case (w.i_fmt.funct3)
          3'b010:  res = {mem[ba + 10'd3], mem[ba + 10'd2], mem[ba + 10'd1], mem[ba]};
          3'b100:  res = {24'b0, mem[ba]};
          default: res = {{24{mem[ba][7]}}, mem[ba]};
        endcase
      end
      rv_pkg::OPC_STORE: begin
        ba = 10'(a + {{20{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo});
        wr = 1'b0;
        for (int k = 0; k < (w.s_fmt.funct3[1] ? 4 : 1); k++) begin
          mem[ba + 10'(k)] = b[8*k +: 8];
        end
      end
      rv_pkg::OPC_SYSTEM: begin
        wr = 1'b0;
        if (w.i_fmt.funct3 == 3'b001 && w.i_fmt.imm == rv_pkg::CSR_TOHOST) begin
          out.push_back(a);
        end
      end
      default: wr = 1'b0;  // Not implemented, no effect
    endcase
    if (wr && w.r_fmt.rd != 5'd0) begin
      x[w.r_fmt.rd] = res;
    end
  end
  return out;
endfunction

// File: testbench/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

  logic                           clk;
  logic                           rst_n;
  logic                           run;
  logic                           prog_we;
  logic [rv_pkg::IMEM_AWIDTH-1:0] prog_addr;
  rv_pkg::inst_t                  prog_data;
  logic [rv_pkg::XLEN-1:0]        csr;
  logic                           csr_we;

  `include "rv_ref_model.svh"

  rv_pkg::inst_t prog [$];   // Program image, word 0 first
  word_q_t       expected;
  string         names [$];  // One label per CSR report
  string         section;

  rv_core i_dut (
    .clk(clk), .rst_n(rst_n), .run(run), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .csr(csr), .csr_we(csr_we)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] want,
                             input logic [31:0] got);
    if (got !== want) begin
      abort_run($sformatf("CHECK FAILED %s: expected %08h, actual %08h", name, want, got));
    end
  endtask

  task automatic emit(input rv_pkg::inst_t w);
    prog.push_back(w);
  endtask

  // LUI plus ADDI, upper part rounded for a negative low half
  task automatic load_imm(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(enc_u(rd, hi[31:12]));
    emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, rd, rd, v[11:0]));
  endtask

  task automatic report(input logic [4:0] rs);
    emit(enc_i(rv_pkg::OPC_SYSTEM, 3'b001, 5'd0, rs, rv_pkg::CSR_TOHOST));
    names.push_back($sformatf("%s #%0d", section, names.size()));
  endtask

  task automatic build_program();
    logic [2:0]    f3;
    logic [11:0]   imm;
    logic [6:0]    odd_ops [5] = '{7'b1100011, 7'b1101111, 7'b1100111, 7'b0010111, 7'b0001111};
    rv_pkg::inst_t w;
    section = "alu_reg";
    for (int f = 0; f < 10; f++) begin
      f3 = (f < 8) ? 3'(f) : ((f == 8) ? 3'b000 : 3'b101);  // 8 and 9 are SUB and SRA
      load_imm(5'd1, $urandom);
      load_imm(5'd2, $urandom);
      emit(enc_r((f < 8) ? 7'h00 : 7'h20, f3, 5'd3, 5'd1, 5'd2));
      report(5'd3);
    end
    section = "alu_imm";
    for (int f = 0; f < 9; f++) begin
      f3  = (f < 8) ? 3'(f) : 3'b101;
      imm = 12'($urandom);
      if (f3 == 3'b001 || f3 == 3'b101) begin
        imm = {1'b0, f == 8, 5'b0, imm[4:0]};  // Bit 10 picks SRAI
      end
      load_imm(5'd1, $urandom);
      emit(enc_i(rv_pkg::OPC_OP_IMM, f3, 5'd3, 5'd1, imm));
      report(5'd3);
    end
    section = "forwarding";
    repeat (3) begin
      load_imm(5'd4, $urandom);
      emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd5, 5'd4, 12'($urandom)));
      emit(enc_r(7'h00, 3'b000, 5'd6, 5'd5, 5'd4));   // x4 at distance two
      emit(enc_r(7'h00, 3'b100, 5'd7, 5'd6, 5'd4));   // x4 at distance three
      emit(enc_r(7'h20, 3'b000, 5'd8, 5'd5, 5'd7));
      emit(enc_r(7'h00, 3'b110, 5'd9, 5'd7, 5'd6));
      emit(enc_r(7'h00, 3'b111, 5'd10, 5'd9, 5'd8));
      report(5'd10);
      report(5'd9);
    end
    section = "load_store";
    emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd20, 5'd0, 12'h100));
    load_imm(5'd11, $urandom | 32'h8000_8080);  // Mostly negative bytes
    emit(enc_s(3'b010, 5'd20, 5'd11, 12'd0));
    emit(enc_s(3'b010, 5'd20, 5'd11, 12'd4));
    for (int off = 0; off < 4; off++) begin
      emit(enc_i(rv_pkg::OPC_LOAD, 3'b000, 5'd12, 5'd20, 12'(off)));  // LB
      report(5'd12);
      emit(enc_i(rv_pkg::OPC_LOAD, 3'b100, 5'd13, 5'd20, 12'(off)));  // LBU
      report(5'd13);
    end
    load_imm(5'd14, $urandom | 32'h80);
    for (int off = 0; off < 4; off++) begin
      emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd14, 5'd14, 12'h035));
      emit(enc_s(3'b000, 5'd20, 5'd14, 12'(4 + off)));  // SB of the value just made
    end
    emit(enc_i(rv_pkg::OPC_LOAD, 3'b010, 5'd15, 5'd20, 12'd4));
    emit(enc_r(7'h00, 3'b000, 5'd16, 5'd15, 5'd11));  // Load-use
    report(5'd16);
    report(5'd15);
    section = "x0_and_unknown";
    emit(enc_i(rv_pkg::OPC_OP_IMM, 3'b000, 5'd0, 5'd1, 12'h7ff));
    emit(enc_u(5'd0, 20'($urandom)));
    emit(enc_r(7'h00, 3'b110, 5'd0, 5'd1, 5'd2));
    report(5'd0);
    foreach (odd_ops[k]) begin
      w              = $urandom;
      w.r_fmt.opcode = odd_ops[k];
      w.r_fmt.rd     = 5'd3;  // Would clobber x3 if executed
      emit(w);
    end
    emit(enc_i(rv_pkg::OPC_SYSTEM, 3'b000, 5'd3, 5'd1, 12'h000));  // ECALL
    emit(enc_i(rv_pkg::OPC_SYSTEM, 3'b001, 5'd0, 5'd1, 12'h340));  // Other CSR
    report(5'd3);
    report(5'd1);
  endtask

  // Returns at the falling edge where the CSR strobe is seen
  task automatic await_csr_write(input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        abort_run("Timeout while waiting for a CSR write from the core");
      end
    end while (!csr_we);
  endtask

  initial begin
    rst_n     = 1'b0;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    void'($urandom(77892));
    build_program();
    expected = ref_csr_writes(prog);
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int a = 0; a < 2**rv_pkg::IMEM_AWIDTH; a++) begin
      prog_we   = 1'b1;
      prog_addr = rv_pkg::IMEM_AWIDTH'(a);
      prog_data = '0;  // Bubbles past the end
      if (a < prog.size()) begin
        prog_data = prog[a];
      end
      @(negedge clk);
    end
    prog_we = 1'b0;
    run     = 1'b1;
  end

  // Compare process
  initial begin
    int waited;
    waited = 0;
    while (!run) begin
      @(negedge clk);
      waited++;
      if (waited > 1000) begin
        abort_run("Timeout while waiting for the program load to finish");
      end
    end
    if (names.size() != expected.size()) begin
      abort_run("Reference model and program disagree on the number of CSR writes");
    end
    foreach (expected[k]) begin
      await_csr_write(64);
      check_value(names[k], expected[k], csr);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule
